//--- dv/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;

    localparam int XLEN = alu_pkg::XLEN_DEFAULT;

    logic            clock;
    logic            arst_n;
    logic            in_valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            wb_valid;
    logic [4:0]      wb_rd;
    logic [XLEN-1:0] wb_data;
    logic            br_valid;
    logic            br_taken;
    logic            illegal;

    logic [31:0]     lfsr = 32'hfcd3;   // Seed
    int              tests_passed = 0;
    int              tests_failed = 0;
    int              fails_before = 0;

    alu_top #(.XLEN(XLEN)) i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;   // 100 ns period
    end

    // ------------------------------------------------------------------------
    // Random bits, Galois LFSR stepped per bit
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [4:0] pick_rd();
        logic [4:0] r;
        r = 5'(rand_bits(5));
        return (r == 5'd0) ? 5'd1 : r;   // Keep clear of x0
    endfunction

    // Instruction builders, register index fields random
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, 10'(rand_bits(10)), f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, 5'(rand_bits(5)), f3, rd, alu_pkg::OPC_OP_IMM};
    endfunction

    task automatic issue(input logic [31:0] ins, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
        @(posedge clock);
        in_valid <= 1'b1;
        instr    <= ins;
        rs1_data <= a;
        rs2_data <= b;
    endtask

    // Drain the pipe, then report the test
    task automatic finish_test(input string name);
        int cycles;
        int new_fails;
        @(posedge clock);
        in_valid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
        end while (i_dut.i_sva.busy && cycles < 20);
        new_fails = i_dut.i_sva.fail_count - fails_before;
        fails_before = i_dut.i_sva.fail_count;
        if (cycles >= 20) begin
            tests_failed++;
            $display("%s: timed out waiting for the pipeline to drain", name);
        end else if (new_fails != 0) begin
            tests_failed++;
            $display("ERR %s got %h exp %h, %s had %0d mismatches",
                     i_dut.i_sva.err_sig, i_dut.i_sva.err_got, i_dut.i_sva.err_exp,
                     name, new_fails);
        end else begin
            tests_passed++;
            $display("%s: ok", name);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [11:0]     imm;
        logic [31:0]     ins;
        logic [2:0]      alu_f3 [6];
        logic [2:0]      br_f3 [6];
        alu_f3 = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        br_f3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        arst_n   = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        rs1_data = '0;
        rs2_data = '0;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;

        finish_test("reset_idle");

        // Each funct3 in both forms, with equal and opposite signs
        for (int i = 0; i < 48; i++) begin
            f3  = alu_f3[(i / 4) % 6];
            a   = rand_bits(32);
            b   = rand_bits(32);
            imm = 12'(rand_bits(12));
            if (i % 4 < 2) b[XLEN-1] = a[XLEN-1];    // Equal signs
            else           b[XLEN-1] = ~a[XLEN-1];   // Opposite signs
            imm[11] = b[XLEN-1];                     // Immediate follows b
            if (i % 2 == 0) issue(r_type((f3 == 3'd0 && i >= 24) ? 7'h20 : 7'h0,
                                         f3, pick_rd(), alu_pkg::OPC_OP), a, b);
            else            issue(i_type(imm, f3, pick_rd()), a, b);
        end
        finish_test("arith_logic");

        for (int s = 0; s < 32; s++) begin
            a = rand_bits(32);
            if (s % 2 == 1) a[XLEN-1] = 1'b1;   // Negative for sra
            issue(r_type(7'h0, 3'd1, pick_rd(), alu_pkg::OPC_OP), a, XLEN'(s) | 32'hffe0);
            issue(r_type(7'h0, 3'd5, pick_rd(), alu_pkg::OPC_OP), a, XLEN'(s));
            issue(r_type(7'h20, 3'd5, pick_rd(), alu_pkg::OPC_OP), a, XLEN'(s));
            issue(i_type({7'h0, 5'(s)}, 3'd5, pick_rd()), a, '0);
            issue(i_type({7'h20, 5'(s)}, 3'd5, pick_rd()), a, '0);
            issue(i_type({7'h0, 5'(s)}, 3'd1, pick_rd()), a, '0);
            issue({20'(rand_bits(20)), pick_rd(), alu_pkg::OPC_LUI}, a, a);
        end
        finish_test("shift_lui");

        // Every condition on equal, less and greater pairs
        for (int i = 0; i < 36; i++) begin
            a = rand_bits(32);
            if (i % 4 == 3) a = 32'h7fffffff;   // Signed overflow edge
            case ((i / 6) % 3)
                0:       b = a;
                1:       b = a + 1;   // a less
                default: b = a - 1;   // a greater
            endcase
            // Second half, signed and unsigned disagree
            if (i >= 18 && b != a) b[XLEN-1] = ~b[XLEN-1];
            issue({7'(rand_bits(7)), 10'(rand_bits(10)), br_f3[i % 6], 5'(rand_bits(5)),
                   alu_pkg::OPC_BRANCH}, a, b);
        end
        finish_test("branches");

        issue(r_type(7'h0, 3'd0, 5'd0, alu_pkg::OPC_OP), 32'h5, 32'h6);
        issue(i_type(12'h123, 3'd6, 5'd0), 32'h1, '0);
        issue({20'habcde, 5'd0, alu_pkg::OPC_LUI}, '0, '0);
        issue({25'h0, 7'b0000011}, 32'h1, 32'h2);   // Load
        issue({25'h7, 7'b0100011}, 32'h1, 32'h2);   // Store
        issue({25'h3, 7'b1101111}, 32'h1, 32'h2);   // JAL
        issue({25'h9, 7'b0010111}, 32'h1, 32'h2);   // AUIPC
        issue({17'h0, 3'd2, 5'd0, alu_pkg::OPC_BRANCH}, 32'h1, 32'h1);
        issue(r_type(7'h20, 3'd7, 5'd3, alu_pkg::OPC_OP), 32'h1, 32'h2);
        finish_test("x0_illegal");

        for (int i = 0; i < 80; i++) begin
            case (2'(rand_bits(2)))
                2'd0:    ins = {rand_bits(1) ? 7'h20 : 7'h0, 25'(rand_bits(25))};
                2'd1:    ins = rand_bits(32);
                default: ins = {25'(rand_bits(25)), 7'h0};
            endcase
            case (3'(rand_bits(3)))
                3'd0, 3'd1: ins[6:0] = alu_pkg::OPC_OP;
                3'd2, 3'd3: ins[6:0] = alu_pkg::OPC_OP_IMM;
                3'd4:       ins[6:0] = alu_pkg::OPC_LUI;
                3'd5, 3'd6: ins[6:0] = alu_pkg::OPC_BRANCH;
                default:    ins[6:0] = 7'b0000011;
            endcase
            issue(ins, rand_bits(32), rand_bits(32));
        end
        finish_test("back_to_back");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && i_dut.i_sva.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/alu_tb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb_sva #(
    parameter int XLEN = 32
) (
    input wire logic            clock,
    input wire logic            arst_n,
    input wire logic            in_valid,
    input wire logic [31:0]     instr,
    input wire logic [XLEN-1:0] rs1_data,
    input wire logic [XLEN-1:0] rs2_data,
    input wire logic            wb_valid,
    input wire logic [4:0]      wb_rd,
    input wire logic [XLEN-1:0] wb_data,
    input wire logic            br_valid,
    input wire logic            br_taken,
    input wire logic            illegal
);

    localparam int SHW = $clog2(XLEN);
    localparam logic [1:0] K_NONE = 2'd0;   // Write to x0, no strobe
    localparam logic [1:0] K_WB   = 2'd1;
    localparam logic [1:0] K_BR   = 2'd2;
    localparam logic [1:0] K_ILL  = 2'd3;

    int              fail_count = 0;
    string           err_sig = "";
    logic [XLEN-1:0] err_got = '0;
    logic [XLEN-1:0] err_exp = '0;

    // ------------------------------------------------------------------------
    // Input shadow, one slot per pipeline stage
    // ------------------------------------------------------------------------
    logic [2:0]      sh_v;
    logic [31:0]     sh_instr [3];
    logic [XLEN-1:0] sh_a [3];
    logic [XLEN-1:0] sh_b [3];
    logic            busy;

    assign busy = |sh_v;   // Something still in flight

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) sh_v <= '0;
        else         sh_v <= {sh_v[1:0], in_valid};
    end

    always_ff @(posedge clock) begin
        sh_instr[0] <= instr;
        sh_a[0]     <= rs1_data;
        sh_b[0]     <= rs2_data;
        for (int i = 1; i < 3; i++) begin
            sh_instr[i] <= sh_instr[i-1];
            sh_a[i]     <= sh_a[i-1];
            sh_b[i]     <= sh_b[i-1];
        end
    end

    // ------------------------------------------------------------------------
    // Reference model of the instruction rules
    // ------------------------------------------------------------------------
    function automatic void ref_model(input logic [31:0] ins, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b, output logic [1:0] kind,
                                      output logic [XLEN-1:0] val, output logic taken);
        logic [6:0]      opc;
        logic [6:0]      f7;
        logic [2:0]      f3;
        logic [XLEN-1:0] opb;
        logic [SHW-1:0]  sh;
        logic            alt;
        logic            ill;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        alt   = (f7 == 7'h20);
        kind  = K_WB;
        val   = '0;
        taken = 1'b0;
        ill   = 1'b0;
        case (opc)
            alu_pkg::OPC_OP, alu_pkg::OPC_OP_IMM: begin
                if (opc == alu_pkg::OPC_OP) opb = b;
                else                        opb = {{(XLEN-12){ins[31]}}, ins[31:20]};
                sh = opb[SHW-1:0];
                case (f3)
                    3'd0: val = (opc == alu_pkg::OPC_OP && alt) ? a - opb : a + opb;
                    3'd1: val = a << sh;
                    3'd2: val = XLEN'($signed(a) < $signed(opb));
                    3'd3: val = XLEN'(a < opb);
                    3'd4: val = a ^ opb;
                    3'd5: val = alt ? XLEN'($signed(a) >>> sh) : a >> sh;
                    3'd6: val = a | opb;
                    default: val = a & opb;
                endcase
                if (opc == alu_pkg::OPC_OP) ill = !(f7 == 7'h0 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
                else ill = (f3 == 3'd1 && f7 != 7'h0) || (f3 == 3'd5 && f7 != 7'h0 && !alt);
                if (ill)                   kind = K_ILL;
                else if (ins[11:7] == 5'd0) kind = K_NONE;
            end
            alu_pkg::OPC_LUI: begin
                val = XLEN'(signed'({ins[31:12], 12'b0}));
                if (ins[11:7] == 5'd0) kind = K_NONE;
            end
            alu_pkg::OPC_BRANCH: begin
                kind = K_BR;
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) <  $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a <  b);
                    3'd7: taken = (a >= b);
                    default: kind = K_ILL;   // funct3 010, 011
                endcase
            end
            default: kind = K_ILL;
        endcase
    endfunction

    logic [1:0]      exp_kind;
    logic [XLEN-1:0] exp_val;
    logic            exp_taken;

    always_comb ref_model(sh_instr[2], sh_a[2], sh_b[2], exp_kind, exp_val, exp_taken);

    function automatic void note_err(input string sig, input logic [XLEN-1:0] got,
                                     input logic [XLEN-1:0] exp);
        fail_count++;
        err_sig = sig;
        err_got = got;
        err_exp = exp;
        $error("ERR %s got %h exp %h", sig, got, exp);
    endfunction

    // ------------------------------------------------------------------------
    // Output checks, three cycles after the input
    // ------------------------------------------------------------------------
    ap_wb_valid: assert property (@(posedge clock) disable iff (!arst_n)
        wb_valid == (sh_v[2] && exp_kind == K_WB))
        else note_err("wb_valid", XLEN'($sampled(wb_valid)),
                      XLEN'($sampled(sh_v[2] && exp_kind == K_WB)));

    ap_br_valid: assert property (@(posedge clock) disable iff (!arst_n)
        br_valid == (sh_v[2] && exp_kind == K_BR))
        else note_err("br_valid", XLEN'($sampled(br_valid)),
                      XLEN'($sampled(sh_v[2] && exp_kind == K_BR)));

    ap_illegal: assert property (@(posedge clock) disable iff (!arst_n)
        illegal == (sh_v[2] && exp_kind == K_ILL))
        else note_err("illegal", XLEN'($sampled(illegal)),
                      XLEN'($sampled(sh_v[2] && exp_kind == K_ILL)));

    ap_wb_data: assert property (@(posedge clock) disable iff (!arst_n)
        wb_valid |-> wb_data == exp_val)
        else note_err("wb_data", $sampled(wb_data), $sampled(exp_val));

    ap_wb_rd: assert property (@(posedge clock) disable iff (!arst_n)
        wb_valid |-> wb_rd == sh_instr[2][11:7])
        else note_err("wb_rd", XLEN'($sampled(wb_rd)), XLEN'($sampled(sh_instr[2][11:7])));

    ap_br_taken: assert property (@(posedge clock) disable iff (!arst_n)
        br_valid |-> br_taken == exp_taken)
        else note_err("br_taken", XLEN'($sampled(br_taken)), XLEN'($sampled(exp_taken)));

endmodule

bind alu_top alu_tb_sva #(.XLEN(XLEN)) i_sva (
    .clock(clock), .arst_n(arst_n), .in_valid(in_valid), .instr(instr),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .wb_valid(wb_valid), .wb_rd(wb_rd),
    .wb_data(wb_data), .br_valid(br_valid), .br_taken(br_taken), .illegal(illegal)
);

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module alu_tb -o alu_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
(./obj_dir/alu_sim +verilator+error+limit+100000 > sim.log 2>&1 || true) \
    && grep -q "^RESULT: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- source/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decode #(
    parameter int XLEN = alu_pkg::XLEN_DEFAULT
) (
    input  wire logic            clock,
    input  wire logic            arst_n,
    input  wire logic            in_valid,
    input  wire logic [31:0]     instr,
    input  wire logic [XLEN-1:0] rs1_data,
    input  wire logic [XLEN-1:0] rs2_data,
    alu_req_if.source            req
);

    // ------------------------------------------------------------------------
    // Field split and immediates
    // ------------------------------------------------------------------------
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [XLEN-1:0]  imm_i;
    logic [XLEN-1:0]  imm_u;
    logic             f7_base;
    logic             f7_alt;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign imm_i   = XLEN'(signed'(instr[31:20]));          // I-type, sign extended
    assign imm_u   = XLEN'(signed'({instr[31:12], 12'b0})); // U-type
    assign f7_base = (funct7 == alu_pkg::F7_BASE);
    assign f7_alt  = (funct7 == alu_pkg::F7_ALT);

    // Next request
    alu_pkg::alu_op_e d_op;
    logic [XLEN-1:0]  d_a;
    logic [XLEN-1:0]  d_b;
    logic             d_is_branch;
    logic             d_br_negate;
    logic             d_illegal;

    always_comb begin
        d_op        = alu_pkg::ALU_NONE;
        d_a         = rs1_data;
        d_b         = rs2_data;
        d_is_branch = 1'b0;
        d_br_negate = 1'b0;
        d_illegal   = 1'b0;
        case (opcode)
            alu_pkg::OPC_OP, alu_pkg::OPC_OP_IMM: begin
                case (funct3)
                    alu_pkg::F3_ADD_SUB: begin
                        // Only OP has sub, addi ignores funct7
                        if (opcode == alu_pkg::OPC_OP && f7_alt) d_op = alu_pkg::ALU_SUB;
                        else                                      d_op = alu_pkg::ALU_ADD;
                    end
                    alu_pkg::F3_SLL:     d_op = alu_pkg::ALU_SLL;
                    alu_pkg::F3_SLT:     d_op = alu_pkg::ALU_SCMP;
                    alu_pkg::F3_SLTU:    d_op = alu_pkg::ALU_UCMP;
                    alu_pkg::F3_XOR:     d_op = alu_pkg::ALU_XOR;
                    alu_pkg::F3_SRL_SRA: d_op = f7_alt ? alu_pkg::ALU_SRA : alu_pkg::ALU_SRL;
                    alu_pkg::F3_OR:      d_op = alu_pkg::ALU_OR;
                    default:             d_op = alu_pkg::ALU_AND;
                endcase
                if (opcode == alu_pkg::OPC_OP) begin
                    // Alternate funct7 only on add/sub and srl/sra
                    d_illegal = !(f7_base || (f7_alt && (funct3 == alu_pkg::F3_ADD_SUB ||
                                                         funct3 == alu_pkg::F3_SRL_SRA)));
                end else begin
                    d_b = imm_i;
                    // Shift immediates carry funct7 in imm[11:5]
                    d_illegal = (funct3 == alu_pkg::F3_SLL && !f7_base) ||
                                (funct3 == alu_pkg::F3_SRL_SRA && !(f7_base || f7_alt));
                end
            end
            alu_pkg::OPC_LUI: begin
                d_op = alu_pkg::ALU_ADD;   // 0 + imm
                d_a  = '0;
                d_b  = imm_u;
            end
            alu_pkg::OPC_BRANCH: begin
                d_is_branch = 1'b1;
                case (funct3)
                    alu_pkg::F3_BEQ:  d_op = alu_pkg::ALU_EQ;
                    alu_pkg::F3_BNE: begin
                        d_op        = alu_pkg::ALU_EQ;
                        d_br_negate = 1'b1;
                    end
                    alu_pkg::F3_BLT:  d_op = alu_pkg::ALU_SCMP;
                    alu_pkg::F3_BGE: begin
                        d_op        = alu_pkg::ALU_SCMP;
                        d_br_negate = 1'b1;      // ge is not lt
                    end
                    alu_pkg::F3_BLTU: d_op = alu_pkg::ALU_UCMP;
                    alu_pkg::F3_BGEU: begin
                        d_op        = alu_pkg::ALU_UCMP;
                        d_br_negate = 1'b1;
                    end
                    default:          d_illegal = 1'b1;   // funct3 010, 011
                endcase
            end
            default: d_illegal = 1'b1;    // Loads, stores, jumps, AUIPC, system
        endcase
        // Illegal wins over everything else
        if (d_illegal) begin
            d_op        = alu_pkg::ALU_NONE;
            d_is_branch = 1'b0;
            d_br_negate = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Request register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) req.valid <= 1'b0;
        else         req.valid <= in_valid;
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin          // Hold payload when idle
            req.op        <= d_op;
            req.a         <= d_a;
            req.b         <= d_b;
            req.rd        <= instr[11:7];
            req.is_branch <= d_is_branch;
            req.br_negate <= d_br_negate;
            req.illegal   <= d_illegal;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute #(
    parameter int XLEN = alu_pkg::XLEN_DEFAULT
) (
    input  wire logic clock,
    input  wire logic arst_n,
    alu_req_if.sink   req,
    alu_rsp_if.source rsp
);

    localparam int SHW = $clog2(XLEN);   // Shift amount width
    localparam int MSB = XLEN - 1;

    // ------------------------------------------------------------------------
    // Shared adder, a + b or a + ~b + 1
    // ------------------------------------------------------------------------
    logic             sub_sel;
    logic [XLEN-1:0]  b_eff;
    logic [XLEN-1:0]  sum;
    logic [SHW-1:0]   shamt;

    assign sub_sel = (req.op == alu_pkg::ALU_SUB) || (req.op == alu_pkg::ALU_SCMP);
    assign b_eff   = sub_sel ? ~req.b : req.b;                   // Invert for subtract
    assign sum     = req.a + b_eff + {{(XLEN-1){1'b0}}, sub_sel}; // Carry-in of one
    assign shamt   = req.b[SHW-1:0];                              // Upper bits ignored

    // ------------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------------
    logic [XLEN-1:0] alu_res;

    always_comb begin
        alu_res = '0;
        case (req.op)
            alu_pkg::ALU_SCMP: begin
                // Signs differ, a negative means a < b
                if (req.a[MSB] != req.b[MSB]) alu_res[0] = req.a[MSB];
                else                          alu_res[0] = sum[MSB];  // Sign of a - b
            end
            alu_pkg::ALU_UCMP: alu_res[0] = (req.a < req.b);
            alu_pkg::ALU_ADD,
            alu_pkg::ALU_SUB:  alu_res    = sum;
            alu_pkg::ALU_AND:  alu_res    = req.a & req.b;
            alu_pkg::ALU_OR:   alu_res    = req.a | req.b;
            alu_pkg::ALU_XOR:  alu_res    = req.a ^ req.b;
            alu_pkg::ALU_EQ:   alu_res[0] = (req.a == req.b);
            alu_pkg::ALU_SLL:  alu_res    = req.a << shamt;
            alu_pkg::ALU_SRL:  alu_res    = req.a >> shamt;
            alu_pkg::ALU_SRA:  alu_res    = XLEN'($signed(req.a) >>> shamt);  // Sign fill
            default:           alu_res    = '0;   // ALU_NONE
        endcase
    end

    // ------------------------------------------------------------------------
    // Response register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) rsp.valid <= 1'b0;
        else         rsp.valid <= req.valid;
    end

    // Side fields follow the result
    always_ff @(posedge clock) begin
        if (req.valid) begin
            rsp.res       <= alu_res;
            rsp.rd        <= req.rd;
            rsp.is_branch <= req.is_branch;
            rsp.br_negate <= req.br_negate;
            rsp.illegal   <= req.illegal;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // ------------------------------------------------------------------------
    // ALU operation codes
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_SCMP = 4'd0,   // Signed less-than, bit 0 only
        ALU_UCMP = 4'd1,   // Unsigned less-than
        ALU_ADD  = 4'd2,
        ALU_SUB  = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_EQ   = 4'd7,   // Equality, bit 0 only
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,  // Sign of a shifted in
        ALU_NONE = 4'd15   // Illegal or no operation, result zero
    } alu_op_e;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    // funct7, base and alternate (sub, sra)
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    // Data width used unless the top level overrides it
    localparam int XLEN_DEFAULT = 32;

endpackage

`default_nettype wire

//--- source/alu_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded operation, decode to execute
interface alu_req_if #(
    parameter int XLEN = alu_pkg::XLEN_DEFAULT
) ();

    logic                  valid;      // One-cycle strobe
    alu_pkg::alu_op_e      op;
    logic [XLEN-1:0]       a;          // rs1 or zero
    logic [XLEN-1:0]       b;          // rs2 or immediate
    logic [4:0]            rd;
    logic                  is_branch;
    logic                  br_negate;  // bne, bge, bgeu
    logic                  illegal;

    modport source (
        output valid, op, a, b, rd, is_branch, br_negate, illegal
    );

    modport sink (
        input  valid, op, a, b, rd, is_branch, br_negate, illegal
    );

endinterface

`default_nettype wire

//--- source/alu_result.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result #(
    parameter int XLEN = alu_pkg::XLEN_DEFAULT
) (
    input  wire logic            clock,
    input  wire logic            arst_n,
    alu_rsp_if.sink              rsp,
    output logic                 wb_valid,
    output logic [4:0]           wb_rd,
    output logic [XLEN-1:0]      wb_data,
    output logic                 br_valid,
    output logic                 br_taken,
    output logic                 illegal
);

    // Response class
    logic rsp_br;
    logic rsp_wb;

    assign rsp_br = rsp.is_branch && !rsp.illegal;
    // x0 is hardwired zero, no write-back
    assign rsp_wb = !rsp.is_branch && !rsp.illegal && (rsp.rd != 5'd0);

    // ------------------------------------------------------------------------
    // Output strobes
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wb_valid <= rsp.valid && rsp_wb;
            br_valid <= rsp.valid && rsp_br;
            illegal  <= rsp.valid && rsp.illegal;   // Nothing else raised
        end
    end

    // Payload, valid only with its strobe
    always_ff @(posedge clock) begin
        if (rsp.valid) begin
            wb_rd    <= rsp.rd;
            wb_data  <= rsp.res;
            br_taken <= rsp.res[0] ^ rsp.br_negate;   // bne/bge/bgeu flip
        end
    end

endmodule

`default_nettype wire

//--- source/alu_rsp_if.sv
`timescale 1ns/1ps
`default_nettype none

// Executed result, execute to result stage
interface alu_rsp_if #(
    parameter int XLEN = alu_pkg::XLEN_DEFAULT
) ();

    logic                  valid;      // One-cycle strobe
    logic [XLEN-1:0]       res;        // ALU result, compares in bit 0
    logic [4:0]            rd;
    logic                  is_branch;
    logic                  br_negate;
    logic                  illegal;

    // Execute drives
    modport source (
        output valid, res, rd, is_branch, br_negate, illegal
    );

    // Result stage reads
    modport sink (
        input  valid, res, rd, is_branch, br_negate, illegal
    );

endinterface

`default_nettype wire

//--- source/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top #(
    parameter int XLEN = alu_pkg::XLEN_DEFAULT
) (
    input  wire logic            clock,
    input  wire logic            arst_n,
    // Instruction in
    input  wire logic            in_valid,
    input  wire logic [31:0]     instr,
    input  wire logic [XLEN-1:0] rs1_data,
    input  wire logic [XLEN-1:0] rs2_data,
    // Write-back out
    output logic                 wb_valid,
    output logic [4:0]           wb_rd,
    output logic [XLEN-1:0]      wb_data,
    // Branch decision out
    output logic                 br_valid,
    output logic                 br_taken,
    output logic                 illegal
);

    // ------------------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------------------
    alu_req_if #(.XLEN(XLEN)) req_if ();   // Decode to execute
    alu_rsp_if #(.XLEN(XLEN)) rsp_if ();   // Execute to result

    alu_decode #(.XLEN(XLEN)) u_decode (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .req      (req_if)
    );

    alu_execute #(.XLEN(XLEN)) u_execute (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (req_if),
        .rsp    (rsp_if)
    );

    alu_result #(.XLEN(XLEN)) u_result (
        .clock    (clock),
        .arst_n   (arst_n),
        .rsp      (rsp_if),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .br_valid (br_valid),
        .br_taken (br_taken),
        .illegal  (illegal)
    );

endmodule

`default_nettype wire

//--- vlog.f
source/alu_pkg.sv
source/alu_req_if.sv
source/alu_rsp_if.sv
source/alu_decode.sv
source/alu_execute.sv
source/alu_result.sv
source/alu_top.sv
dv/alu_tb_sva.sv
dv/alu_tb.sv
